/* logic/lc3b_pkg.sv */
package lc3b_pkg;

	// basic widths.
	localparam int word_bits = 16;  // lc3b address and data word.
	localparam int line_bits = 128;  // eight words per line.

	// address split for the l1 and the victim buffer.
	localparam int offset_bits = 4;  // byte within the line.
	localparam int index_bits = 3;  // l1 set select.
	localparam int l1_tag_bits = 9;  // upper bits above the set.
	localparam int line_tag_bits = 12;  // full line address.

	// geometry.
	localparam int l1_sets = 8;  // direct mapped, one line per set.
	localparam int victim_entries = 4;  // fully associative.
	localparam int victim_slot_bits = $clog2(victim_entries);  // slot index and lru rank.

	typedef logic [word_bits-1:0] lc3b_word;
	typedef logic [line_bits-1:0] lc3b_cache_line;
	typedef logic [victim_slot_bits-1:0] victim_slot_t;

	// cpu side request, held until resp.
	typedef struct packed {
		logic read;  // read strobe.
		logic write;  // write strobe.
		logic [1:0] byte_enable;  // bit 1 is the high byte.
		lc3b_word address;  // byte address.
		lc3b_word wdata;  // write word.
	} mem_req_t;

	// line side request, held until resp.
	typedef struct packed {
		logic read;  // line fetch.
		logic write;  // line write out.
		logic dirty;  // line modified since fill.
		lc3b_word address;  // line aligned.
		lc3b_cache_line wdata;  // whole line.
	} line_req_t;

	// l1 controller.
	typedef enum logic [1:0] {
		l1_idle,  // lookup, hit serviced here.
		l1_evict,  // old line out to the line port.
		l1_fill,  // new line in.
		l1_respond  // one cycle resp to the cpu.
	} l1_state_e;

	// victim buffer sequencer.
	typedef enum logic [1:0] {
		vc_idle,  // lookup and install.
		vc_writeback,  // dirty lru line to pmem.
		vc_fetch,  // miss read from pmem.
		vc_done  // one cycle resp to the l1 side.
	} victim_state_e;

endpackage

/* logic/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache #(
	parameter bit writable = 1'b1  // 0 gives a read only cache.
) (
	input logic clk,
	input logic reset,
	input lc3b_pkg::mem_req_t cpu_req,
	output lc3b_pkg::lc3b_word cpu_rdata,
	output logic cpu_resp,
	output lc3b_pkg::line_req_t line_req,
	input lc3b_pkg::lc3b_cache_line line_rdata,
	input logic line_dirty,
	input logic line_resp
);

	// storage arrays.
	logic [lc3b_pkg::l1_tag_bits-1:0] tag_array [lc3b_pkg::l1_sets];
	lc3b_pkg::lc3b_cache_line data_array [lc3b_pkg::l1_sets];
	logic [lc3b_pkg::l1_sets-1:0] valid;  // per set.

	lc3b_pkg::l1_state_e state, next_state;

	// address fields of the held request.
	logic [lc3b_pkg::l1_tag_bits-1:0] tag;
	logic [lc3b_pkg::index_bits-1:0] index;
	logic [lc3b_pkg::offset_bits-2:0] word_sel;  // word within the line.

	logic access;  // read or write pending.
	logic hit;
	logic do_write;  // write that may modify the line.
	logic hit_now;  // lookup hit while idle.
	logic set_dirty;  // dirty bit of the addressed set.
	lc3b_pkg::lc3b_cache_line cur_line, merged_line;

	assign tag = cpu_req.address[lc3b_pkg::word_bits-1 -: lc3b_pkg::l1_tag_bits];
	assign index = cpu_req.address[lc3b_pkg::offset_bits +: lc3b_pkg::index_bits];
	assign word_sel = cpu_req.address[lc3b_pkg::offset_bits-1:1];

	assign access = cpu_req.read | cpu_req.write;
	assign hit = valid[index] && (tag_array[index] == tag);
	assign do_write = writable && cpu_req.write;  // icache ignores write data.
	assign hit_now = (state == lc3b_pkg::l1_idle) && access && hit;
	assign cur_line = data_array[index];

	// byte merge of the write word into the current line.
	always_comb begin
		merged_line = cur_line;
		if (cpu_req.byte_enable[0])
			merged_line[word_sel*lc3b_pkg::word_bits +: 8] = cpu_req.wdata[7:0];
		if (cpu_req.byte_enable[1])
			merged_line[word_sel*lc3b_pkg::word_bits + 8 +: 8] = cpu_req.wdata[15:8];
	end

	// dirty tracking exists only on the data side.
	if (writable) begin : g_dirty
		logic [lc3b_pkg::l1_sets-1:0] dirty;

		always_ff @(posedge clk) begin
			if (reset) begin
				dirty <= '0;
			end else if (hit_now && do_write) begin
				dirty[index] <= 1'b1;  // write hit marks the line.
			end else if (state == lc3b_pkg::l1_fill && line_resp) begin
				dirty[index] <= line_dirty;  // refill keeps the victim's dirty bit.
			end
		end

		assign set_dirty = dirty[index];
	end else begin : g_clean
		assign set_dirty = 1'b0;  // instruction lines are never modified.
	end

	// next state.
	always_comb begin
		next_state = state;
		unique case (state)
			lc3b_pkg::l1_idle: begin
				if (access && hit)
					next_state = lc3b_pkg::l1_respond;
				else if (access)
					next_state = valid[index] ? lc3b_pkg::l1_evict : lc3b_pkg::l1_fill;
			end
			lc3b_pkg::l1_evict: begin
				if (line_resp)
					next_state = lc3b_pkg::l1_fill;
			end
			lc3b_pkg::l1_fill: begin
				if (line_resp)
					next_state = lc3b_pkg::l1_idle;  // lookup again, now a hit.
			end
			lc3b_pkg::l1_respond: begin
				next_state = lc3b_pkg::l1_idle;
			end
		endcase
	end

	// control state.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= lc3b_pkg::l1_idle;
			valid <= '0;
		end else begin
			state <= next_state;
			if (state == lc3b_pkg::l1_fill && line_resp)
				valid[index] <= 1'b1;
		end
	end

	// arrays and read word.
	always_ff @(posedge clk) begin
		if (hit_now) begin
			cpu_rdata <= cur_line[word_sel*lc3b_pkg::word_bits +: lc3b_pkg::word_bits];
			if (do_write)
				data_array[index] <= merged_line;  // visible in the resp cycle.
		end else if (state == lc3b_pkg::l1_fill && line_resp) begin
			data_array[index] <= line_rdata;
			tag_array[index] <= tag;
		end
	end

	assign cpu_resp = (state == lc3b_pkg::l1_respond);

	// line port, held for the whole evict or fill.
	always_comb begin
		line_req = '0;
		line_req.read = (state == lc3b_pkg::l1_fill);
		line_req.write = (state == lc3b_pkg::l1_evict);
		line_req.dirty = (state == lc3b_pkg::l1_evict) && set_dirty;
		if (state == lc3b_pkg::l1_evict)
			line_req.address = {tag_array[index], index, {lc3b_pkg::offset_bits{1'b0}}};
		else
			line_req.address = {tag, index, {lc3b_pkg::offset_bits{1'b0}}};
		line_req.wdata = cur_line;  // old line on evict.
	end

endmodule

/* logic/line_arbiter.sv */
`timescale 1ns/1ps

module line_arbiter (
	input logic clk,
	input logic reset,
	input lc3b_pkg::line_req_t i_req,
	input lc3b_pkg::line_req_t d_req,
	output lc3b_pkg::lc3b_cache_line i_rdata,
	output lc3b_pkg::lc3b_cache_line d_rdata,
	output logic i_dirty,
	output logic d_dirty,
	output logic i_resp,
	output logic d_resp,
	output lc3b_pkg::line_req_t req,
	input lc3b_pkg::lc3b_cache_line rdata,
	input logic dirty,
	input logic resp
);

	logic busy;  // a transaction owns the port.
	logic owner_d;  // 1 for the data side.
	logic i_pending, d_pending;
	logic i_owns, d_owns;

	assign i_pending = i_req.read | i_req.write;
	assign d_pending = d_req.read | d_req.write;

	// grant register, taken only while free.
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			owner_d <= 1'b0;
		end else if (!busy) begin
			if (d_pending || i_pending) begin
				busy <= 1'b1;
				owner_d <= d_pending;  // data wins ties.
			end
		end else if (resp) begin
			busy <= 1'b0;  // free in the cycle after resp.
		end
	end

	assign i_owns = busy && !owner_d;
	assign d_owns = busy && owner_d;

	// only the owner's request goes down.
	always_comb begin
		req = '0;
		if (d_owns)
			req = d_req;
		else if (i_owns)
			req = i_req;
	end

	// responses back to the owner only.
	assign i_resp = i_owns && resp;
	assign d_resp = d_owns && resp;
	assign i_dirty = i_owns && dirty;
	assign d_dirty = d_owns && dirty;
	assign i_rdata = i_owns ? rdata : '0;
	assign d_rdata = d_owns ? rdata : '0;

endmodule

/* logic/victim_cache.sv */
`timescale 1ns/1ps

module victim_cache (
	input logic clk,
	input logic reset,
	input lc3b_pkg::line_req_t l1_req,
	output lc3b_pkg::lc3b_cache_line l1_rdata,
	output logic l1_dirty,
	output logic l1_resp,
	input lc3b_pkg::lc3b_cache_line pmem_rdata,
	input logic pmem_resp,
	output lc3b_pkg::lc3b_word pmem_address,
	output lc3b_pkg::lc3b_cache_line pmem_wdata,
	output logic pmem_read,
	output logic pmem_write
);

	// entry storage.
	logic [lc3b_pkg::line_tag_bits-1:0] tag_q [lc3b_pkg::victim_entries];
	lc3b_pkg::lc3b_cache_line line_q [lc3b_pkg::victim_entries];
	logic [lc3b_pkg::victim_entries-1:0] valid_q;
	logic [lc3b_pkg::victim_entries-1:0] dirty_q;
	lc3b_pkg::victim_slot_t rank_q [lc3b_pkg::victim_entries];  // 0 is most recent.

	lc3b_pkg::victim_state_e state, next_state;
	lc3b_pkg::victim_slot_t slot_q;  // entry being written back.

	logic [lc3b_pkg::line_tag_bits-1:0] req_tag;
	logic hit, has_free;
	lc3b_pkg::victim_slot_t hit_slot, free_slot, lru_slot, target;
	logic wb_needed;  // full and the lru line is dirty.
	logic install;  // take the l1 line into an entry.
	lc3b_pkg::victim_slot_t install_slot;
	logic read_hit;  // swap out on an idle read.

	assign req_tag = l1_req.address[lc3b_pkg::word_bits-1 -: lc3b_pkg::line_tag_bits];

	// parallel lookup over all entries.
	always_comb begin
		hit = 1'b0;
		hit_slot = '0;
		has_free = 1'b0;
		free_slot = '0;
		lru_slot = '0;
		for (int i = 0; i < lc3b_pkg::victim_entries; i++) begin
			if (valid_q[i] && tag_q[i] == req_tag) begin
				hit = 1'b1;
				hit_slot = lc3b_pkg::victim_slot_t'(i);
			end
			if (!valid_q[i] && !has_free) begin
				has_free = 1'b1;  // lowest free slot.
				free_slot = lc3b_pkg::victim_slot_t'(i);
			end
			if (rank_q[i] == lc3b_pkg::victim_slot_t'(lc3b_pkg::victim_entries - 1))
				lru_slot = lc3b_pkg::victim_slot_t'(i);
		end
	end

	// write target: same line, then a free entry, then lru.
	assign target = hit ? hit_slot : (has_free ? free_slot : lru_slot);
	assign wb_needed = !hit && !has_free && dirty_q[lru_slot];

	assign read_hit = (state == lc3b_pkg::vc_idle) && !l1_req.write && l1_req.read && hit;
	assign install = ((state == lc3b_pkg::vc_idle) && l1_req.write && !wb_needed)
		|| ((state == lc3b_pkg::vc_writeback) && pmem_resp);
	assign install_slot = (state == lc3b_pkg::vc_writeback) ? slot_q : target;

	// sequencer.
	always_comb begin
		next_state = state;
		unique case (state)
			lc3b_pkg::vc_idle: begin
				if (l1_req.write)
					next_state = wb_needed ? lc3b_pkg::vc_writeback : lc3b_pkg::vc_done;
				else if (l1_req.read)
					next_state = hit ? lc3b_pkg::vc_done : lc3b_pkg::vc_fetch;
			end
			lc3b_pkg::vc_writeback: begin
				if (pmem_resp)
					next_state = lc3b_pkg::vc_done;  // install happens on the same edge.
			end
			lc3b_pkg::vc_fetch: begin
				if (pmem_resp)
					next_state = lc3b_pkg::vc_done;
			end
			lc3b_pkg::vc_done: begin
				next_state = lc3b_pkg::vc_idle;
			end
		endcase
	end

	// control state, valid, dirty and lru order.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= lc3b_pkg::vc_idle;
			valid_q <= '0;
			dirty_q <= '0;
			slot_q <= '0;
			for (int i = 0; i < lc3b_pkg::victim_entries; i++)
				rank_q[i] <= lc3b_pkg::victim_slot_t'(i);  // any permutation works.
		end else begin
			state <= next_state;
			if (state == lc3b_pkg::vc_idle && l1_req.write)
				slot_q <= target;
			if (read_hit)
				valid_q[hit_slot] <= 1'b0;  // line moves back to the l1.
			if (install) begin
				valid_q[install_slot] <= 1'b1;
				dirty_q[install_slot] <= l1_req.dirty;
				for (int i = 0; i < lc3b_pkg::victim_entries; i++)
					if (rank_q[i] < rank_q[install_slot])
						rank_q[i] <= rank_q[i] + 1'b1;  // age the newer ones.
				rank_q[install_slot] <= '0;  // now most recent.
			end
		end
	end

	// payload.
	always_ff @(posedge clk) begin
		if (install) begin
			tag_q[install_slot] <= req_tag;
			line_q[install_slot] <= l1_req.wdata;
		end
		if (read_hit) begin
			l1_rdata <= line_q[hit_slot];
			l1_dirty <= dirty_q[hit_slot];  // dirtiness follows the line.
		end else if (state == lc3b_pkg::vc_fetch && pmem_resp) begin
			l1_rdata <= pmem_rdata;
			l1_dirty <= 1'b0;  // fresh from memory.
		end
	end

	assign l1_resp = (state == lc3b_pkg::vc_done);

	// physical memory port, stable through each state.
	assign pmem_read = (state == lc3b_pkg::vc_fetch);
	assign pmem_write = (state == lc3b_pkg::vc_writeback);
	assign pmem_wdata = line_q[slot_q];
	assign pmem_address = (state == lc3b_pkg::vc_writeback)
		? {tag_q[slot_q], {lc3b_pkg::offset_bits{1'b0}}}
		: {req_tag, {lc3b_pkg::offset_bits{1'b0}}};

endmodule

/* logic/mem_hierarchy.sv */
`timescale 1ns/1ps

module mem_hierarchy (
	input logic clk,
	input logic reset,
	input lc3b_pkg::mem_req_t i_req,
	output lc3b_pkg::lc3b_word i_rdata,
	output logic i_resp,
	input lc3b_pkg::mem_req_t d_req,
	output lc3b_pkg::lc3b_word d_rdata,
	output logic d_resp,
	input logic pmem_resp,
	input lc3b_pkg::lc3b_cache_line pmem_rdata,
	output lc3b_pkg::lc3b_word pmem_address,
	output lc3b_pkg::lc3b_cache_line pmem_wdata,
	output logic pmem_read,
	output logic pmem_write
);

	// l1 line ports.
	lc3b_pkg::line_req_t i_line_req, d_line_req;
	lc3b_pkg::lc3b_cache_line i_line_rdata, d_line_rdata;
	logic i_line_dirty, d_line_dirty;
	logic i_line_resp, d_line_resp;

	// arbiter to victim buffer.
	lc3b_pkg::line_req_t v_req;
	lc3b_pkg::lc3b_cache_line v_rdata;
	logic v_dirty, v_resp;

	l1_cache #(.writable(1'b0)) icache (  // read only.
		.clk,
		.reset,
		.cpu_req(i_req),
		.cpu_rdata(i_rdata),
		.cpu_resp(i_resp),
		.line_req(i_line_req),
		.line_rdata(i_line_rdata),
		.line_dirty(i_line_dirty),
		.line_resp(i_line_resp)
	);

	l1_cache #(.writable(1'b1)) dcache (
		.clk,
		.reset,
		.cpu_req(d_req),
		.cpu_rdata(d_rdata),
		.cpu_resp(d_resp),
		.line_req(d_line_req),
		.line_rdata(d_line_rdata),
		.line_dirty(d_line_dirty),
		.line_resp(d_line_resp)
	);

	line_arbiter arbiter (
		.clk,
		.reset,
		.i_req(i_line_req),
		.d_req(d_line_req),
		.i_rdata(i_line_rdata),
		.d_rdata(d_line_rdata),
		.i_dirty(i_line_dirty),
		.d_dirty(d_line_dirty),
		.i_resp(i_line_resp),
		.d_resp(d_line_resp),
		.req(v_req),
		.rdata(v_rdata),
		.dirty(v_dirty),
		.resp(v_resp)
	);

	victim_cache victim (  // talks straight to pmem.
		.clk,
		.reset,
		.l1_req(v_req),
		.l1_rdata(v_rdata),
		.l1_dirty(v_dirty),
		.l1_resp(v_resp),
		.pmem_rdata,
		.pmem_resp,
		.pmem_address,
		.pmem_wdata,
		.pmem_read,
		.pmem_write
	);

endmodule

/* tests/mem_hierarchy_checker.sv */
`timescale 1ns/1ps

module mem_hierarchy_checker (
	input logic clk,
	input logic reset,
	input lc3b_pkg::mem_req_t i_req,
	input logic i_resp,
	input lc3b_pkg::mem_req_t d_req,
	input logic d_resp,
	input logic pmem_resp,
	input lc3b_pkg::lc3b_word pmem_address,
	input logic pmem_read,
	input logic pmem_write
);

	int unsigned failures = 0;  // read by the testbench at the end.

	no_double_strobe: assert property (@(posedge clk) disable iff (reset)
		!(pmem_read && pmem_write))
	else begin
		$error("pmem_read and pmem_write high together");
		failures++;
	end

	// request held until the memory answers.
	pmem_hold: assert property (@(posedge clk) disable iff (reset)
		(pmem_read || pmem_write) && !pmem_resp
		|=> $stable(pmem_read) && $stable(pmem_write) && $stable(pmem_address))
	else begin
		$error("pmem request changed before pmem_resp");
		failures++;
	end

	resp_needs_req: assert property (@(posedge clk) disable iff (reset)
		(i_resp |-> (i_req.read || i_req.write)) and (d_resp |-> (d_req.read || d_req.write)))
	else begin
		$error("cpu resp without a pending request");
		failures++;
	end

	quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !pmem_read && !pmem_write && !i_resp && !d_resp)
	else begin
		$error("strobe in the first cycle after reset");
		failures++;
	end

endmodule

bind mem_hierarchy mem_hierarchy_checker handshake_checks (.*);

/* tests/mem_hierarchy_tb.sv */
`timescale 1ns/1ps

module mem_hierarchy_tb;

	localparam int resp_timeout = 400;  // cycles allowed per cpu request.

	bit clk;  // starts low, first edge is the rise at 2 ns.
	logic reset;
	lc3b_pkg::mem_req_t i_req, d_req;
	lc3b_pkg::lc3b_word i_rdata, d_rdata, pmem_address;
	logic i_resp, d_resp, pmem_resp, pmem_read, pmem_write;
	lc3b_pkg::lc3b_cache_line pmem_rdata, pmem_wdata;

	logic [31:0] stim_state, mem_state;  // separate lfsr streams.
	lc3b_pkg::lc3b_word ref_mem [16384];  // data region with one entry per word.
	lc3b_pkg::lc3b_cache_line pmem_lines [4096];  // only lines written back.
	logic [4095:0] pmem_written;
	int checks, errors, test_start, read_starts, write_count, mem_delay;
	logic mem_busy;  // a pmem request is being timed.
	lc3b_pkg::lc3b_word waddr;
	lc3b_pkg::lc3b_word addr_list [16], data_list [16], i_list [16];
	logic [1:0] be_list [16];

	mem_hierarchy dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period.
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois with taps 32 22 2 1.
	endfunction

	// one lfsr step per bit taken.
	function automatic logic [15:0] take_bits(inout logic [31:0] state, input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			state = lfsr_step(state);
			v = {v[14:0], state[0]};
		end
		return v;
	endfunction

	// instruction words are never written.
	function automatic lc3b_pkg::lc3b_word ref_word(input lc3b_pkg::lc3b_word addr);
		return addr[15] ? (addr ^ 16'h5a5a) : ref_mem[addr[14:1]];
	endfunction

	function automatic lc3b_pkg::lc3b_cache_line read_line(input logic [11:0] line_idx);
		lc3b_pkg::lc3b_cache_line l;
		if (pmem_written[line_idx])
			return pmem_lines[line_idx];
		for (int w = 0; w < 8; w++)
			l[w*16 +: 16] = {line_idx, w[2:0], 1'b0} ^ 16'h5a5a;  // untouched pattern.
		return l;
	endfunction

	task automatic check_word(input string name, input lc3b_pkg::lc3b_word got,
		input lc3b_pkg::lc3b_word exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_quiet();
		check_word("i_resp", 16'(i_resp), 16'h0);
		check_word("d_resp", 16'(d_resp), 16'h0);
		check_word("pmem_read", 16'(pmem_read), 16'h0);
		check_word("pmem_write", 16'(pmem_write), 16'h0);
	endtask

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic report_test(input string name);
		$display("test %-14s %s, %0d errors", name, (errors == test_start) ? "ok" : "failed",
			errors - test_start);
		test_start = errors;
	endtask

	// drive at a falling edge and hold through the resp cycle.
	task automatic port_access(input bit data_side, input lc3b_pkg::mem_req_t req,
		output lc3b_pkg::lc3b_word rdata);
		int waited;
		waited = 0;
		if (data_side)
			d_req = req;
		else
			i_req = req;
		do begin
			@(negedge clk);
			waited++;
			if (waited > resp_timeout)
				abort_run(data_side ? "data port never answered" : "instruction port never answered");
		end while (!(data_side ? d_resp : i_resp));
		rdata = data_side ? d_rdata : i_rdata;
		@(negedge clk);  // resp cycle ends here.
		if (data_side)
			d_req = '0;
		else
			i_req = '0;
	endtask

	task automatic write_data(input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word wdata,
		input logic [1:0] be);
		lc3b_pkg::mem_req_t req;
		lc3b_pkg::lc3b_word unused;
		req = '{read: 1'b0, write: 1'b1, byte_enable: be, address: addr, wdata: wdata};
		port_access(1'b1, req, unused);
		if (be[0])
			ref_mem[addr[14:1]][7:0] = wdata[7:0];  // low byte lane.
		if (be[1])
			ref_mem[addr[14:1]][15:8] = wdata[15:8];
	endtask

	task automatic read_check(input bit data_side, input lc3b_pkg::lc3b_word addr);
		lc3b_pkg::mem_req_t req;
		lc3b_pkg::lc3b_word got;
		req = '{read: 1'b1, write: 1'b0, byte_enable: 2'b11, address: addr, wdata: 16'h0};
		port_access(data_side, req, got);
		check_word($sformatf("%s[%h]", data_side ? "d_rdata" : "i_rdata", addr), got, ref_word(addr));
	endtask

	// pmem model answering 1 to 4 cycles after a request.
	always @(negedge clk) begin
		if (pmem_resp) begin
			pmem_resp = 1'b0;  // one cycle pulse.
		end else if (!reset && (pmem_read || pmem_write)) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				mem_delay = int'(take_bits(mem_state, 2));
				if (pmem_read)
					read_starts++;
			end
			if (mem_delay == 0) begin
				if (pmem_read) begin
					pmem_rdata = read_line(pmem_address[15:4]);
				end else begin
					for (int w = 0; w < 8; w++) begin
						waddr = {pmem_address[15:4], w[2:0], 1'b0};
						check_word($sformatf("pmem_wdata[%h]", waddr), pmem_wdata[w*16 +: 16],
							ref_word(waddr));
					end
					pmem_lines[pmem_address[15:4]] = pmem_wdata;
					pmem_written[pmem_address[15:4]] = 1'b1;
					write_count++;
				end
				mem_busy = 1'b0;
				pmem_resp = 1'b1;
			end else begin
				mem_delay--;
			end
		end
	end

	initial begin
		int count;
		stim_state = 32'hb6e4;
		mem_state = 32'hb6e4;
		checks = 0;
		errors = 0;
		test_start = 0;
		read_starts = 0;
		write_count = 0;
		mem_delay = 0;
		mem_busy = 1'b0;
		pmem_written = '0;
		for (int k = 0; k < 16384; k++)
			ref_mem[k] = {1'b0, k[13:0], 1'b0} ^ 16'h5a5a;
		reset = 1'b1;
		i_req = '0;
		d_req = '0;
		pmem_resp = 1'b0;
		pmem_rdata = '0;

		repeat (10) begin
			@(negedge clk);
			check_quiet();
		end
		reset = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_quiet();
		end
		report_test("reset_state");

		for (int n = 0; n < 16; n++) begin
			addr_list[n] = take_bits(stim_state, 14) << 1;  // anywhere below 8000.
			data_list[n] = take_bits(stim_state, 16);
			be_list[n] = 2'(take_bits(stim_state, 2));
			write_data(addr_list[n], data_list[n], be_list[n]);
		end
		for (int n = 0; n < 16; n++)
			read_check(1'b1, addr_list[n]);
		report_test("data_rw");

		for (int n = 0; n < 16; n++)
			read_check(1'b0, 16'h8000 | (take_bits(stim_state, 14) << 1));
		report_test("instr_reads");

		for (int n = 0; n < 5; n++)
			read_check(1'b1, 16'(16'h1050 + n * 16'h0800));  // set 5 with five tags.
		count = read_starts;
		read_check(1'b1, 16'h1850);  // second line, still in the victim buffer.
		checks++;
		assert (read_starts == count) else begin
			$display("victim hit on line 1850 still read physical memory");
			errors++;
		end
		report_test("victim_hit");

		count = write_count;
		for (int n = 0; n < 14; n++) begin
			addr_list[n] = 16'(16'h0020 + n * 16'h0400) + (take_bits(stim_state, 3) << 1);  // set 2.
			data_list[n] = take_bits(stim_state, 16);
			write_data(addr_list[n], data_list[n], 2'b11);
		end
		checks++;
		assert (write_count - count >= 13 - lc3b_pkg::victim_entries) else begin
			$display("too few dirty lines reached physical memory");
			errors++;
		end
		for (int n = 0; n < 14; n++)
			read_check(1'b1, addr_list[n]);
		report_test("dirty_writeback");

		for (int n = 0; n < 16; n++) begin
			i_list[n] = 16'h8000 | (take_bits(stim_state, 9) << 1);
			addr_list[n] = take_bits(stim_state, 9) << 1;  // small window for hits.
			data_list[n] = take_bits(stim_state, 16);
			be_list[n] = 2'(take_bits(stim_state, 2));
		end
		fork
			for (int n = 0; n < 16; n++)
				read_check(1'b0, i_list[n]);
			for (int n = 0; n < 16; n++) begin
				write_data(addr_list[n], data_list[n], be_list[n]);
				read_check(1'b1, addr_list[n]);
			end
		join
		report_test("concurrent");

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			dut.handshake_checks.failures);
		if (errors == 0 && dut.handshake_checks.failures == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* files.f */
logic/lc3b_pkg.sv
logic/l1_cache.sv
logic/line_arbiter.sv
logic/victim_cache.sv
logic/mem_hierarchy.sv
tests/mem_hierarchy_checker.sv
tests/mem_hierarchy_tb.sv

/* Bender.yml */
package:
  name: lc3b_mem_hierarchy

sources:
  # design, package first
  - logic/lc3b_pkg.sv
  - logic/l1_cache.sv
  - logic/line_arbiter.sv
  - logic/victim_cache.sv
  - logic/mem_hierarchy.sv

  # testbench and bound assertions
  - target: test
    files:
      - tests/mem_hierarchy_checker.sv
      - tests/mem_hierarchy_tb.sv
